//--- bp_core_pkg.sv
package bp_core_pkg;

    // Fixed by the ISA, all pcs and targets are byte addresses of this width
    localparam int ADDR_WIDTH = 32;

    // Program counter or branch target
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Outcome of a branch, also used for the prediction of one
    typedef enum logic
    {
        NOT_TAKEN = 1'b0,
        TAKEN     = 1'b1
    } branch_outcome_e;

    // Byte distance from a branch to the instruction after its delay slot
    localparam addr_t DELAY_SLOT_STEP = 'd8;

    // Instructions are word aligned, so the two low pc bits carry no information
    localparam int PC_WORD_SHIFT = 2;

endpackage

//--- bp_pred_pkg.sv
package bp_pred_pkg;

    // Two-bit saturating counter of one table entry
    // Encoded in ascending order so the top bit is the prediction
    typedef enum logic [1:0]
    {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_state_e;

    // Every entry starts here, one taken update away from a taken prediction
    localparam counter_state_e COUNTER_INIT = WEAK_NT;

    // Table of 2**4 = 16 counters
    localparam int DEFAULT_INDEX_BITS = 4;

    // Width of the resolved-branch and misprediction counters
    localparam int DEFAULT_COUNT_WIDTH = 16;

endpackage

//--- bp_counter_table.sv
`timescale 1ns/1ps

module bp_counter_table #(
    parameter int INDEX_BITS = bp_pred_pkg::DEFAULT_INDEX_BITS
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // Lookup from decode
    input  logic [INDEX_BITS-1:0]        i_rd_index,
    output bp_core_pkg::branch_outcome_e o_rd_prediction,

    // Training from execute
    input  logic                         i_wr_valid,
    input  logic [INDEX_BITS-1:0]        i_wr_index,
    input  bp_core_pkg::branch_outcome_e i_wr_outcome
);

    localparam int NUM_ENTRIES = 2 ** INDEX_BITS;

    bp_pred_pkg::counter_state_e counters_q [NUM_ENTRIES];

    bp_pred_pkg::counter_state_e rd_state;      // Entry seen by the lookup
    bp_pred_pkg::counter_state_e wr_state;      // Entry being trained
    bp_pred_pkg::counter_state_e wr_state_next; // Its value after this edge

    // One step toward strongly taken, holding at the top
    function automatic bp_pred_pkg::counter_state_e step_up(
        input bp_pred_pkg::counter_state_e state
    );
        bp_pred_pkg::counter_state_e next;
        case (state)
            bp_pred_pkg::STRONG_NT: next = bp_pred_pkg::WEAK_NT;
            bp_pred_pkg::WEAK_NT:   next = bp_pred_pkg::WEAK_T;
            bp_pred_pkg::WEAK_T:    next = bp_pred_pkg::STRONG_T;
            default:                next = bp_pred_pkg::STRONG_T;
        endcase
        return next;
    endfunction

    // One step toward strongly not taken, holding at the bottom
    function automatic bp_pred_pkg::counter_state_e step_down(
        input bp_pred_pkg::counter_state_e state
    );
        bp_pred_pkg::counter_state_e next;
        case (state)
            bp_pred_pkg::STRONG_T:  next = bp_pred_pkg::WEAK_T;
            bp_pred_pkg::WEAK_T:    next = bp_pred_pkg::WEAK_NT;
            bp_pred_pkg::WEAK_NT:   next = bp_pred_pkg::STRONG_NT;
            default:                next = bp_pred_pkg::STRONG_NT;
        endcase
        return next;
    endfunction

    // Next value of the trained entry
    always_comb
    begin
        wr_state = counters_q[i_wr_index];
        if (i_wr_outcome == bp_core_pkg::TAKEN)
        begin
            wr_state_next = step_up(wr_state);
        end
        else
        begin
            wr_state_next = step_down(wr_state);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_ENTRIES; i++)
            begin
                counters_q[i] <= bp_pred_pkg::COUNTER_INIT;
            end
        end
        else if (i_wr_valid)
        begin
            counters_q[i_wr_index] <= wr_state_next;
        end
    end

    // Read straight from the registers, so a write shows from the next cycle
    always_comb
    begin
        rd_state = counters_q[i_rd_index];
        if (rd_state[1])  // Upper half of the range
        begin
            o_rd_prediction = bp_core_pkg::TAKEN;
        end
        else
        begin
            o_rd_prediction = bp_core_pkg::NOT_TAKEN;
        end
    end

endmodule

//--- bp_stats.sv
`timescale 1ns/1ps

module bp_stats #(
    parameter int COUNT_WIDTH = bp_pred_pkg::DEFAULT_COUNT_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // Feedback of one resolved conditional branch
    input  logic                         i_fb_valid,
    input  bp_core_pkg::branch_outcome_e i_fb_prediction,
    input  bp_core_pkg::branch_outcome_e i_fb_outcome,

    output logic [COUNT_WIDTH-1:0]       o_branch_count,
    output logic [COUNT_WIDTH-1:0]       o_mispredict_count
);

    typedef logic [COUNT_WIDTH-1:0] count_t;

    count_t branch_count_q;
    count_t mispredict_count_q;
    logic   mispredicted;

    // Add one unless already at all ones
    function automatic count_t sat_incr(input count_t value);
        count_t result;
        if (&value)
        begin
            result = value;
        end
        else
        begin
            result = value + count_t'(1);
        end
        return result;
    endfunction

    assign mispredicted = (i_fb_prediction != i_fb_outcome);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            branch_count_q     <= '0;
            mispredict_count_q <= '0;
        end
        else if (i_fb_valid)
        begin
            branch_count_q <= sat_incr(branch_count_q);
            if (mispredicted)
            begin
                mispredict_count_q <= sat_incr(mispredict_count_q);
            end
        end
    end

    assign o_branch_count     = branch_count_q;
    assign o_mispredict_count = mispredict_count_q;

endmodule

//--- branch_controller.sv
`timescale 1ns/1ps

module branch_controller #(
    parameter int INDEX_BITS  = bp_pred_pkg::DEFAULT_INDEX_BITS,
    parameter int COUNT_WIDTH = bp_pred_pkg::DEFAULT_COUNT_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // Request from decode
    input  logic                         i_dec_valid,
    input  logic                         i_dec_is_jump,
    input  bp_core_pkg::addr_t           i_dec_pc,
    input  bp_core_pkg::addr_t           i_dec_target,
    output bp_core_pkg::branch_outcome_e o_dec_prediction,
    output bp_core_pkg::addr_t           o_dec_recovery_target,

    // Feedback from execute, conditional branches only
    input  logic                         i_ex_valid,
    input  bp_core_pkg::addr_t           i_ex_pc,
    input  bp_core_pkg::branch_outcome_e i_ex_prediction,
    input  bp_core_pkg::branch_outcome_e i_ex_outcome,

    // Statistics
    output logic [COUNT_WIDTH-1:0]       o_branch_count,
    output logic [COUNT_WIDTH-1:0]       o_mispredict_count
);

    localparam int INDEX_LSB = bp_core_pkg::PC_WORD_SHIFT;
    localparam int INDEX_MSB = INDEX_LSB + INDEX_BITS - 1;

    logic [INDEX_BITS-1:0]        dec_index;
    logic [INDEX_BITS-1:0]        ex_index;
    bp_core_pkg::branch_outcome_e table_prediction;

    // Word index bits of each pc select the counter
    assign dec_index = i_dec_pc[INDEX_MSB:INDEX_LSB];
    assign ex_index  = i_ex_pc[INDEX_MSB:INDEX_LSB];

    bp_counter_table #(
        .INDEX_BITS (INDEX_BITS)
    ) i_counter_table (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_rd_index      (dec_index),
        .o_rd_prediction (table_prediction),
        .i_wr_valid      (i_ex_valid),
        .i_wr_index      (ex_index),
        .i_wr_outcome    (i_ex_outcome)
    );

    bp_stats #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_stats (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_fb_valid         (i_ex_valid),
        .i_fb_prediction    (i_ex_prediction),
        .i_fb_outcome       (i_ex_outcome),
        .o_branch_count     (o_branch_count),
        .o_mispredict_count (o_mispredict_count)
    );

    always_comb
    begin
        if (!i_dec_valid)
        begin
            o_dec_prediction = bp_core_pkg::NOT_TAKEN;  // Nothing in decode
        end
        else if (i_dec_is_jump)
        begin
            o_dec_prediction = bp_core_pkg::TAKEN;      // Jumps always go
        end
        else
        begin
            o_dec_prediction = table_prediction;
        end

        // Fetch address if the prediction turns out wrong
        if (o_dec_prediction == bp_core_pkg::TAKEN)
        begin
            o_dec_recovery_target = i_dec_pc + bp_core_pkg::DELAY_SLOT_STEP;
        end
        else
        begin
            o_dec_recovery_target = i_dec_target;
        end
    end

endmodule

//--- bp_assertions.sv
`timescale 1ns/1ps

module bp_assertions #(
    parameter int COUNT_WIDTH = bp_pred_pkg::DEFAULT_COUNT_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_dec_valid,
    input  logic                         i_dec_is_jump,
    input  bp_core_pkg::branch_outcome_e o_dec_prediction,
    input  logic [COUNT_WIDTH-1:0]       o_branch_count,
    input  logic [COUNT_WIDTH-1:0]       o_mispredict_count
);

    int failure_count = 0;  // Assertion failures so far

    jump_taken: assert property (@(posedge clk) disable iff (!rst_n)
        (i_dec_valid && i_dec_is_jump) |-> (o_dec_prediction == bp_core_pkg::TAKEN))
    else
    begin
        failure_count = failure_count + 1;
        $error("valid jump request was not predicted taken");
    end

    // Saturating counts only ever hold or grow
    counts_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        (o_branch_count >= $past(o_branch_count)) &&
        (o_mispredict_count >= $past(o_mispredict_count)))
    else
    begin
        failure_count = failure_count + 1;
        $error("statistics count decreased");
    end

    mispredict_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        o_mispredict_count <= o_branch_count)
    else
    begin
        failure_count = failure_count + 1;
        $error("misprediction count exceeds branch count");
    end

endmodule

bind branch_controller bp_assertions #(
    .COUNT_WIDTH (COUNT_WIDTH)
) i_assertions (
    .clk                (clk),
    .rst_n              (rst_n),
    .i_dec_valid        (i_dec_valid),
    .i_dec_is_jump      (i_dec_is_jump),
    .o_dec_prediction   (o_dec_prediction),
    .o_branch_count     (o_branch_count),
    .o_mispredict_count (o_mispredict_count)
);

//--- bp_checker.sv
`timescale 1ns/1ps

module bp_checker #(
    parameter int INDEX_BITS  = bp_pred_pkg::DEFAULT_INDEX_BITS,
    parameter int COUNT_WIDTH = bp_pred_pkg::DEFAULT_COUNT_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_dec_valid,
    input  logic                         i_dec_is_jump,
    input  bp_core_pkg::addr_t           i_dec_pc,
    input  bp_core_pkg::addr_t           i_dec_target,
    input  bp_core_pkg::branch_outcome_e o_dec_prediction,
    input  bp_core_pkg::addr_t           o_dec_recovery_target,
    input  logic                         i_ex_valid,
    input  bp_core_pkg::addr_t           i_ex_pc,
    input  bp_core_pkg::branch_outcome_e i_ex_prediction,
    input  bp_core_pkg::branch_outcome_e i_ex_outcome,
    input  logic [COUNT_WIDTH-1:0]       o_branch_count,
    input  logic [COUNT_WIDTH-1:0]       o_mispredict_count,
    output int                           o_error_count,
    output int                           o_check_count
);

    localparam int NUM_ENTRIES = 2 ** INDEX_BITS;

    int                           model_counters [NUM_ENTRIES];  // 0 strong NT up to 3 strong T
    logic [COUNT_WIDTH-1:0]       model_branches;
    logic [COUNT_WIDTH-1:0]       model_mispredicts;
    bp_core_pkg::branch_outcome_e exp_prediction;
    bp_core_pkg::addr_t           exp_recovery;
    logic [INDEX_BITS-1:0]        fb_index;
    int                           error_count = 0;
    int                           check_count = 0;

    assign o_error_count = error_count;
    assign o_check_count = check_count;

    // Word address modulo the table size
    function automatic logic [INDEX_BITS-1:0] table_index(input bp_core_pkg::addr_t pc);
        return INDEX_BITS'(pc >> 2);
    endfunction

    // Expected decode response from the request and the model state
    function automatic void reference_response(
        input  logic                         valid,
        input  logic                         is_jump,
        input  bp_core_pkg::addr_t           pc,
        input  bp_core_pkg::addr_t           target,
        output bp_core_pkg::branch_outcome_e prediction,
        output bp_core_pkg::addr_t           recovery
    );
        if (!valid)
        begin
            prediction = bp_core_pkg::NOT_TAKEN;
        end
        else if (is_jump || model_counters[table_index(pc)] >= 2)
        begin
            prediction = bp_core_pkg::TAKEN;
        end
        else
        begin
            prediction = bp_core_pkg::NOT_TAKEN;
        end
        recovery = (prediction == bp_core_pkg::TAKEN) ? pc + 32'd8 : target;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count = check_count + 1;
        if (expected !== actual)
        begin
            error_count = error_count + 1;
            $display("mismatch at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_ENTRIES; i++)
            begin
                model_counters[i] = 1;  // Weakly not taken
            end
            model_branches    = '0;
            model_mispredicts = '0;
        end
        else
        begin
            // Compare against pre-edge state, then apply this edge's feedback
            reference_response(i_dec_valid, i_dec_is_jump, i_dec_pc, i_dec_target,
                               exp_prediction, exp_recovery);
            compare_value("o_dec_prediction", 32'(exp_prediction), 32'(o_dec_prediction));
            compare_value("o_dec_recovery_target", exp_recovery, o_dec_recovery_target);
            compare_value("o_branch_count", 32'(model_branches), 32'(o_branch_count));
            compare_value("o_mispredict_count", 32'(model_mispredicts),
                          32'(o_mispredict_count));
            if (i_ex_valid)
            begin
                fb_index = table_index(i_ex_pc);
                if (i_ex_outcome == bp_core_pkg::TAKEN && model_counters[fb_index] < 3)
                begin
                    model_counters[fb_index] = model_counters[fb_index] + 1;
                end
                else if (i_ex_outcome == bp_core_pkg::NOT_TAKEN &&
                         model_counters[fb_index] > 0)
                begin
                    model_counters[fb_index] = model_counters[fb_index] - 1;
                end
                if (model_branches != '1)
                begin
                    model_branches = model_branches + 1'b1;
                end
                if (i_ex_prediction != i_ex_outcome && model_mispredicts != '1)
                begin
                    model_mispredicts = model_mispredicts + 1'b1;
                end
            end
        end
    end

endmodule

//--- tb_branch_controller.sv
`timescale 1ns/1ps

module tb_branch_controller;

    localparam int INDEX_BITS  = 4;
    localparam int COUNT_WIDTH = 16;
    localparam int NUM_ENTRIES = 2 ** INDEX_BITS;

    // Phase lengths in cycles, summed into the timeout
    localparam int RESET_CYCLES   = 16;
    localparam int TRAIN_STEPS    = NUM_ENTRIES + 8;
    localparam int JUMP_STEPS     = 48;
    localparam int STATS_STEPS    = 64;
    localparam int MIXED_STEPS    = 256;
    localparam int MARGIN_CYCLES  = 200;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ENTRIES + TRAIN_STEPS + JUMP_STEPS +
                                    STATS_STEPS + MIXED_STEPS + MARGIN_CYCLES;

    logic                         clk;
    logic                         rst_n;
    logic                         dec_valid;
    logic                         dec_is_jump;
    bp_core_pkg::addr_t           dec_pc;
    bp_core_pkg::addr_t           dec_target;
    bp_core_pkg::branch_outcome_e dec_prediction;
    bp_core_pkg::addr_t           dec_recovery_target;
    logic                         ex_valid;
    bp_core_pkg::addr_t           ex_pc;
    bp_core_pkg::branch_outcome_e ex_prediction;
    bp_core_pkg::branch_outcome_e ex_outcome;
    logic [COUNT_WIDTH-1:0]       branch_count;
    logic [COUNT_WIDTH-1:0]       mispredict_count;
    int                           error_count;
    int                           check_count;
    int                           errors_before = 0;
    int                           checks_before = 0;
    int                           total_errors;
    int                           cycle_count = 0;
    logic [31:0]                  lcg_state = 32'h272bc951;

    branch_controller #(
        .INDEX_BITS  (INDEX_BITS),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_dut (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .i_dec_valid           (dec_valid),
        .i_dec_is_jump         (dec_is_jump),
        .i_dec_pc              (dec_pc),
        .i_dec_target          (dec_target),
        .o_dec_prediction      (dec_prediction),
        .o_dec_recovery_target (dec_recovery_target),
        .i_ex_valid            (ex_valid),
        .i_ex_pc               (ex_pc),
        .i_ex_prediction       (ex_prediction),
        .i_ex_outcome          (ex_outcome),
        .o_branch_count        (branch_count),
        .o_mispredict_count    (mispredict_count)
    );

    bp_checker #(
        .INDEX_BITS  (INDEX_BITS),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_checker (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .i_dec_valid           (dec_valid),
        .i_dec_is_jump         (dec_is_jump),
        .i_dec_pc              (dec_pc),
        .i_dec_target          (dec_target),
        .o_dec_prediction      (dec_prediction),
        .o_dec_recovery_target (dec_recovery_target),
        .i_ex_valid            (ex_valid),
        .i_ex_pc               (ex_pc),
        .i_ex_prediction       (ex_prediction),
        .i_ex_outcome          (ex_outcome),
        .o_branch_count        (branch_count),
        .o_mispredict_count    (mispredict_count),
        .o_error_count         (error_count),
        .o_check_count         (check_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bp_core_pkg::addr_t random_pc();
        return lcg_next() & 32'hffff_fffc;  // Word aligned
    endfunction

    function automatic bp_core_pkg::addr_t pc_with_index(input int index);
        bp_core_pkg::addr_t pc;
        pc = random_pc();
        pc[INDEX_BITS+1:2] = INDEX_BITS'(index);
        return pc;
    endfunction

    function automatic bp_core_pkg::branch_outcome_e random_outcome();
        logic [31:0] r;
        r = lcg_next();
        return r[16] ? bp_core_pkg::TAKEN : bp_core_pkg::NOT_TAKEN;
    endfunction

    // One cycle of decode and execute inputs, applied on the falling edge
    task automatic drive(input logic dv, input logic dj, input bp_core_pkg::addr_t dpc,
                         input bp_core_pkg::addr_t dtgt, input logic ev,
                         input bp_core_pkg::addr_t epc,
                         input bp_core_pkg::branch_outcome_e epred,
                         input bp_core_pkg::branch_outcome_e eout);
        @(negedge clk);
        dec_valid     = dv;
        dec_is_jump   = dj;
        dec_pc        = dpc;
        dec_target    = dtgt;
        ex_valid      = ev;
        ex_pc         = epc;
        ex_prediction = epred;
        ex_outcome    = eout;
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);  // Last stimulus was checked on the edge before
        dec_valid = 1'b0;
        ex_valid  = 1'b0;
        @(negedge clk);  // Idle edge sees the counts after the last feedback
        $display("test %-10s %0d checks, %0d errors", name,
                 check_count - checks_before, error_count - errors_before);
        checks_before = check_count;
        errors_before = error_count;
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            drive(1'b1, 1'b0, pc_with_index(i), random_pc(), 1'b0, random_pc(),
                  bp_core_pkg::NOT_TAKEN, bp_core_pkg::NOT_TAKEN);
        end
    endtask

    task automatic test_training();
        bp_core_pkg::addr_t pc;
        pc = pc_with_index(5);
        drive(1'b0, 1'b0, pc, 32'd0, 1'b1, pc, random_outcome(), bp_core_pkg::TAKEN);
        drive(1'b1, 1'b0, pc, random_pc(), 1'b0, pc, bp_core_pkg::NOT_TAKEN,
              bp_core_pkg::NOT_TAKEN);  // Now weakly taken
        repeat (2)
        begin
            drive(1'b0, 1'b0, pc, 32'd0, 1'b1, pc, random_outcome(), bp_core_pkg::TAKEN);
        end
        drive(1'b0, 1'b0, pc, 32'd0, 1'b1, pc, random_outcome(), bp_core_pkg::NOT_TAKEN);
        drive(1'b1, 1'b0, pc, random_pc(), 1'b0, pc, bp_core_pkg::NOT_TAKEN,
              bp_core_pkg::NOT_TAKEN);
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            drive(1'b1, 1'b0, pc_with_index(i), random_pc(), 1'b0, pc,
                  bp_core_pkg::NOT_TAKEN, bp_core_pkg::NOT_TAKEN);
        end
    endtask

    task automatic test_jumps_idle();
        logic [31:0] r;
        for (int i = 0; i < JUMP_STEPS; i++)
        begin
            r = lcg_next();
            drive(r[20], r[20] | r[21], random_pc(), random_pc(), 1'b0, random_pc(),
                  bp_core_pkg::NOT_TAKEN, bp_core_pkg::NOT_TAKEN);
        end
    endtask

    task automatic test_statistics();
        logic [31:0] r;
        for (int i = 0; i < STATS_STEPS; i++)
        begin
            r = lcg_next();
            drive(1'b0, 1'b0, random_pc(), random_pc(), r[18] | r[19], random_pc(),
                  random_outcome(), random_outcome());
        end
    endtask

    task automatic test_mixed();
        logic [31:0]        r;
        bp_core_pkg::addr_t pc;
        bp_core_pkg::addr_t epc;
        for (int i = 0; i < MIXED_STEPS; i++)
        begin
            r   = lcg_next();
            pc  = random_pc();
            epc = (r[24:23] == 2'b00) ? pc : random_pc();  // Same-index read and write
            drive(r[18], r[21:19] == 3'b000, pc, random_pc(), r[22], epc,
                  random_outcome(), random_outcome());
        end
    endtask

    initial
    begin
        rst_n         = 1'b0;
        dec_valid     = 1'b0;
        dec_is_jump   = 1'b0;
        dec_pc        = '0;
        dec_target    = '0;
        ex_valid      = 1'b0;
        ex_pc         = '0;
        ex_prediction = bp_core_pkg::NOT_TAKEN;
        ex_outcome    = bp_core_pkg::NOT_TAKEN;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        finish_test("reset");
        test_training();
        finish_test("training");
        test_jumps_idle();
        finish_test("jumps");
        test_statistics();
        finish_test("stats");
        test_mixed();
        finish_test("mixed");

        total_errors = error_count + i_dut.i_assertions.failure_count;
        $display("done: %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, i_dut.i_assertions.failure_count);
        if (total_errors == 0 && check_count > 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
bp_core_pkg.sv
bp_pred_pkg.sv
bp_counter_table.sv
bp_stats.sv
branch_controller.sv
bp_assertions.sv
bp_checker.sv
tb_branch_controller.sv

//--- Makefile
# Verilator build and run of the branch controller testbench
# Any variable below can be overridden on the command line

VERILATOR   ?= verilator
TOP         ?= tb_branch_controller
FILELIST    ?= filelist.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= sim passed
VFLAGS      ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS    ?= +verilator+error+limit+1000

SIM_EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_STRING VFLAGS SIM_ARGS"

$(SIM_EXE): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_EXE)
	-$(SIM_EXE) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_STRING)" $(LOG); then \
		echo "PASS: found '$(PASS_STRING)' in $(LOG)"; \
	else \
		echo "FAIL: '$(PASS_STRING)' not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
